// File: project.f
+incdir+src
src/axil_ram_pkg.sv
src/axil_chan_buf.sv
src/axil_ram_wr.sv
src/axil_ram_rd.sv
src/axil_ram_store.sv
src/axil_ram.sv
tests/axil_ram_checker.sv
tests/axil_ram_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module axil_ram_tb -f project.f -o axil_ram_sim

# Error limit raised so assertion failures reach the end-of-run verdict
./obj_dir/axil_ram_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation passed"

// File: tests/axil_ram_tb.sv
`include "axil_ram_defs.svh"

module axil_ram_tb;

    localparam int WORDS  = `AXIL_RAM_BYTES / (`AXIL_DATA_WIDTH / 8);
    localparam int N_BAD  = 5;
    localparam int N_STRB = 8;
    localparam int N_HOLD = 16;
    localparam int N_MIX  = 300;
    // Fill, bad addresses, strobes, back-pressure, pause pair, random mix
    localparam int TXN_TOTAL = 2 * WORDS + 3 * N_BAD + 2 * N_STRB + 2 * N_HOLD + 2 + N_MIX;

    logic                seq;
    logic                reset;
    logic                pause;
    logic                awvalid;
    axil_ram_pkg::addr_t awaddr;
    logic [2:0]          awprot;
    logic                awready;
    logic                wvalid;
    axil_ram_pkg::data_t wdata;
    axil_ram_pkg::strb_t wstrb;
    logic                wready;
    logic                bvalid;
    axil_ram_pkg::resp_t bresp;
    logic                bready;
    logic                arvalid;
    axil_ram_pkg::addr_t araddr;
    logic [2:0]          arprot;
    logic                arready;
    logic                rvalid;
    axil_ram_pkg::data_t rdata;
    axil_ram_pkg::resp_t rresp;
    logic                rready;

    axil_ram_pkg::data_t model [WORDS]; // Expected memory contents
    int unsigned         lcg_state = 17064;

    axil_ram uut (
        .seq, .reset, .pause,
        .awvalid, .awaddr, .awprot, .awready,
        .wvalid, .wdata, .wstrb, .wready,
        .bvalid, .bresp, .bready,
        .arvalid, .araddr, .arprot, .arready,
        .rvalid, .rdata, .rresp, .rready
    );

    initial begin
        seq = 1'b0;
        forever #2 seq = ~seq;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16]; // Low bits of an LCG are weak
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next()) % n;
    endfunction

    function automatic axil_ram_pkg::data_t rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // Aligned and inside the RAM, otherwise a decode error
    function automatic axil_ram_pkg::resp_t expected_resp(input axil_ram_pkg::addr_t addr);
        if (addr % (`AXIL_DATA_WIDTH / 8) == 0 && addr < `AXIL_RAM_BYTES)
            return axil_ram_pkg::RESP_OKAY;
        else
            return axil_ram_pkg::RESP_DECERR;
    endfunction

    task automatic model_write(input axil_ram_pkg::addr_t addr, input axil_ram_pkg::data_t data,
                               input axil_ram_pkg::strb_t strb);
        int idx;
        idx = int'(addr / (`AXIL_DATA_WIDTH / 8));
        for (int b = 0; b < `AXIL_DATA_WIDTH / 8; b++) begin
            if (strb[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic compare_resp(input string name, input axil_ram_pkg::resp_t got,
                                input axil_ram_pkg::resp_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input axil_ram_pkg::data_t got,
                                input axil_ram_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // AW and W offered together and B held off for hold cycles
    task automatic axi_write(input axil_ram_pkg::addr_t addr, input axil_ram_pkg::data_t data,
                             input axil_ram_pkg::strb_t strb, input int hold,
                             output axil_ram_pkg::resp_t resp);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge seq);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        while (!(aw_done && w_done)) begin
            #1;
            if (awvalid && awready) aw_done = 1'b1; // Transfer at the coming rising edge
            if (wvalid && wready) w_done = 1'b1;
            @(negedge seq);
            if (aw_done) awvalid = 1'b0;
            if (w_done) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge seq);
        resp = bresp;
        repeat (hold) begin
            @(negedge seq);
            if (!bvalid)
                report_failure("bvalid dropped while bready was low");
            else
                compare_resp("bresp", bresp, resp);
        end
        bready = 1'b1;
        @(negedge seq);
        bready = 1'b0;
    endtask

    task automatic axi_read(input axil_ram_pkg::addr_t addr, input int hold,
                            output axil_ram_pkg::resp_t resp, output axil_ram_pkg::data_t data);
        bit done;
        done = 1'b0;
        @(negedge seq);
        arvalid = 1'b1;
        araddr  = addr;
        while (!done) begin
            #1;
            done = arready;
            @(negedge seq);
        end
        arvalid = 1'b0;
        while (!rvalid) @(negedge seq);
        resp = rresp;
        data = rdata;
        repeat (hold) begin
            @(negedge seq);
            if (!rvalid) begin
                report_failure("rvalid dropped while rready was low");
            end else begin
                compare_resp("rresp", rresp, resp);
                compare_data("rdata", rdata, data);
            end
        end
        rready = 1'b1;
        @(negedge seq);
        rready = 1'b0;
    endtask

    task automatic write_check(input axil_ram_pkg::addr_t addr, input axil_ram_pkg::data_t data,
                               input axil_ram_pkg::strb_t strb, input int hold);
        axil_ram_pkg::resp_t resp;
        axi_write(addr, data, strb, hold, resp);
        compare_resp("bresp", resp, expected_resp(addr));
        if (expected_resp(addr) == axil_ram_pkg::RESP_OKAY) model_write(addr, data, strb);
    endtask

    task automatic read_check(input axil_ram_pkg::addr_t addr, input int hold);
        axil_ram_pkg::resp_t resp;
        axil_ram_pkg::data_t data;
        axil_ram_pkg::data_t exp_data;
        axi_read(addr, hold, resp, data);
        compare_resp("rresp", resp, expected_resp(addr));
        if (expected_resp(addr) == axil_ram_pkg::RESP_OKAY)
            exp_data = model[int'(addr / (`AXIL_DATA_WIDTH / 8))];
        else
            exp_data = '0;
        compare_data("rdata", data, exp_data);
    endtask

    task automatic fill_and_readback();
        axil_ram_pkg::addr_t addr;
        for (int i = 0; i < WORDS; i++) begin
            addr = axil_ram_pkg::addr_t'(i * 4);
            write_check(addr, axil_ram_pkg::data_t'(addr), 4'hF, 0);
        end
        for (int i = 0; i < WORDS; i++) begin
            read_check(axil_ram_pkg::addr_t'(i * 4), 0);
        end
    endtask

    task automatic check_bad_addresses();
        axil_ram_pkg::addr_t bad [N_BAD] = '{32'h0000_0102, 32'h0000_1000, 32'h0000_1FFC,
                                            32'h0000_0ABD, 32'hFFFF_FFFC};
        for (int i = 0; i < N_BAD; i++) begin
            write_check(bad[i], rand_word(), 4'hF, 0);
            read_check(bad[i], 0);
            read_check(bad[i] & 32'h0000_0FFC, 0); // Word the bad write could have hit
        end
    endtask

    task automatic check_strobes();
        axil_ram_pkg::strb_t strobes [N_STRB] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                 4'b0101, 4'b1010, 4'b0000, 4'b0110};
        axil_ram_pkg::addr_t addr;
        for (int i = 0; i < N_STRB; i++) begin
            addr = axil_ram_pkg::addr_t'(rand_below(WORDS) * 4);
            write_check(addr, rand_word(), strobes[i], 0);
            read_check(addr, 0);
        end
    endtask

    task automatic check_backpressure();
        axil_ram_pkg::addr_t addr;
        for (int i = 0; i < N_HOLD; i++) begin
            addr = axil_ram_pkg::addr_t'(rand_below(WORDS) * 4);
            write_check(addr, rand_word(), 4'hF, rand_below(16));
            read_check(addr, rand_below(16));
        end
    endtask

    task automatic check_pause();
        axil_ram_pkg::addr_t waddr;
        axil_ram_pkg::addr_t raddr;
        axil_ram_pkg::data_t data;
        waddr = axil_ram_pkg::addr_t'(rand_below(WORDS) * 4);
        raddr = waddr ^ 32'h0000_0800; // Another word, so the order does not matter
        data  = rand_word();
        @(negedge seq);
        pause = 1'b1;
        fork
            write_check(waddr, data, 4'hF, 0);
            read_check(raddr, 0);
            begin
                repeat (10) begin
                    @(negedge seq);
                    #1;
                    if (awready || wready || arready)
                        report_failure("a ready was high while pause was high");
                end
                @(negedge seq);
                pause = 1'b0;
            end
        join
    endtask

    task automatic check_random_mix();
        axil_ram_pkg::addr_t addr;
        for (int i = 0; i < N_MIX; i++) begin
            addr = axil_ram_pkg::addr_t'(rand_below(8192));
            if (rand_below(4) != 0) addr[1:0] = 2'b00; // Mostly aligned
            if (rand_below(2) == 0)
                write_check(addr, rand_word(), axil_ram_pkg::strb_t'(rand_below(16)), 0);
            else
                read_check(addr, 0);
        end
    endtask

    initial begin
        reset   = 1'b1;
        pause   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        awprot  = 3'b000;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arprot  = 3'b000;
        rready  = 1'b0;
        repeat (5) @(posedge seq);
        @(negedge seq);
        reset = 1'b0;
        fill_and_readback();
        check_bad_addresses();
        check_strobes();
        check_backpressure();
        check_pause();
        check_random_mix();
        $display("PASS: all tests");
        $finish;
    end

    // Protocol checker failures end the run as soon as they occur
    initial begin
        wait (uut.chk.fail_count != 0);
        report_failure("the protocol checker flagged an assertion failure");
    end

    // Watchdog
    initial begin
        repeat (200 * TXN_TOTAL) @(posedge seq);
        $display("Timeout: the tests did not finish within %0d cycles", 200 * TXN_TOTAL);
        abort_run();
    end

endmodule

// File: tests/axil_ram_checker.sv
module axil_ram_checker (
    input logic                seq,
    input logic                reset,
    input logic                awvalid,
    input logic                awready,
    input axil_ram_pkg::addr_t awaddr,
    input logic                wvalid,
    input logic                wready,
    input axil_ram_pkg::data_t wdata,
    input axil_ram_pkg::strb_t wstrb,
    input logic                bvalid,
    input logic                bready,
    input axil_ram_pkg::resp_t bresp,
    input logic                arvalid,
    input logic                arready,
    input axil_ram_pkg::addr_t araddr,
    input logic                rvalid,
    input logic                rready,
    input axil_ram_pkg::data_t rdata,
    input axil_ram_pkg::resp_t rresp
);

    int unsigned fail_count = 0; // Watched by the testbench

    aw_stable: assert property (@(posedge seq) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("AW request changed before awready");
            fail_count++;
        end

    w_stable: assert property (@(posedge seq) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            $error("W beat changed before wready");
            fail_count++;
        end

    ar_stable: assert property (@(posedge seq) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("AR request changed before arready");
            fail_count++;
        end

    // Responses held under back-pressure
    b_stable: assert property (@(posedge seq) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("B response changed before bready");
            fail_count++;
        end

    r_stable: assert property (@(posedge seq) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("R response changed before rready");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge seq)
        reset |=> !bvalid && !rvalid && !awready && !wready && !arready
                  && !awvalid && !wvalid && !arvalid)
        else begin
            $error("Valid or ready high right after a reset cycle");
            fail_count++;
        end

endmodule

bind axil_ram axil_ram_checker chk (
    .seq(seq), .reset(reset),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
);

// File: src/axil_ram.sv
`include "axil_ram_defs.svh"

module axil_ram (
    input  logic                  seq,
    input  logic                  reset,
    input  logic                  pause,

    input  logic                  awvalid,
    input  axil_ram_pkg::addr_t   awaddr,
    input  logic [2:0]            awprot,  // Accepted, not decoded
    output logic                  awready,

    input  logic                  wvalid,
    input  axil_ram_pkg::data_t   wdata,
    input  axil_ram_pkg::strb_t   wstrb,
    output logic                  wready,

    output logic                  bvalid,
    output axil_ram_pkg::resp_t   bresp,
    input  logic                  bready,

    input  logic                  arvalid,
    input  axil_ram_pkg::addr_t   araddr,
    input  logic [2:0]            arprot,  // Accepted, not decoded
    output logic                  arready,

    output logic                  rvalid,
    output axil_ram_pkg::data_t   rdata,
    output axil_ram_pkg::resp_t   rresp,
    input  logic                  rready
);

    localparam int DEPTH = `AXIL_RAM_BYTES / (`AXIL_DATA_WIDTH / 8);

    logic                    aw_valid, aw_ready;
    axil_ram_pkg::addr_t     aw_addr;
    logic                    w_valid, w_ready;
    axil_ram_pkg::w_beat_t   w_in, w_beat;
    logic                    ar_valid, ar_ready;
    axil_ram_pkg::addr_t     ar_addr;

    logic                    store_we, store_re;
    axil_ram_pkg::word_idx_t store_widx, store_ridx;
    axil_ram_pkg::data_t     store_wdata, store_rdata;
    axil_ram_pkg::strb_t     store_wstrb;

    assign w_in = '{data: wdata, strb: wstrb};

    axil_chan_buf #(.payload_t(axil_ram_pkg::addr_t)) aw_buf (
        .seq, .reset, .pause,
        .in_valid(awvalid), .in_payload(awaddr), .in_ready(awready),
        .out_valid(aw_valid), .out_payload(aw_addr), .out_ready(aw_ready)
    );

    axil_chan_buf #(.payload_t(axil_ram_pkg::w_beat_t)) w_buf (
        .seq, .reset, .pause,
        .in_valid(wvalid), .in_payload(w_in), .in_ready(wready),
        .out_valid(w_valid), .out_payload(w_beat), .out_ready(w_ready)
    );

    axil_chan_buf #(.payload_t(axil_ram_pkg::addr_t)) ar_buf (
        .seq, .reset, .pause,
        .in_valid(arvalid), .in_payload(araddr), .in_ready(arready),
        .out_valid(ar_valid), .out_payload(ar_addr), .out_ready(ar_ready)
    );

    axil_ram_wr u_wr (
        .seq, .reset,
        .aw_valid, .aw_addr, .aw_ready,
        .w_valid, .w_beat, .w_ready,
        .bvalid, .bresp, .bready,
        .store_we, .store_widx, .store_wdata, .store_wstrb
    );

    axil_ram_rd u_rd (
        .seq, .reset,
        .ar_valid, .ar_addr, .ar_ready,
        .store_re, .store_ridx, .store_rdata,
        .rvalid, .rdata, .rresp, .rready
    );

    axil_ram_store #(.DEPTH(DEPTH)) u_store (
        .seq,
        .we(store_we), .widx(store_widx), .wdata(store_wdata), .wstrb(store_wstrb),
        .re(store_re), .ridx(store_ridx), .rdata(store_rdata)
    );

endmodule

// File: src/axil_ram_store.sv
module axil_ram_store #(
    parameter int DEPTH = 1024
) (
    input  logic                      seq,

    input  logic                      we,
    input  axil_ram_pkg::word_idx_t   widx,
    input  axil_ram_pkg::data_t       wdata,
    input  axil_ram_pkg::strb_t       wstrb,

    input  logic                      re,
    input  axil_ram_pkg::word_idx_t   ridx,
    output axil_ram_pkg::data_t       rdata
);

    localparam int BYTES = $bits(axil_ram_pkg::strb_t);

    axil_ram_pkg::data_t mem [DEPTH];
    axil_ram_pkg::data_t rdata_q;

    assign rdata = rdata_q;

    // Byte lanes written only where the strobe is set
    always_ff @(posedge seq) begin
        if (we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wstrb[b]) mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // Old contents on a same-word read and write
    always_ff @(posedge seq) begin
        if (re) rdata_q <= mem[ridx];
    end

endmodule

// File: src/axil_ram_rd.sv
`include "axil_ram_defs.svh"

module axil_ram_rd (
    input  logic                      seq,
    input  logic                      reset,

    input  logic                      ar_valid,
    input  axil_ram_pkg::addr_t       ar_addr,
    output logic                      ar_ready,

    output logic                      store_re,
    output axil_ram_pkg::word_idx_t   store_ridx,
    input  axil_ram_pkg::data_t       store_rdata,

    output logic                      rvalid,
    output axil_ram_pkg::data_t       rdata,
    output axil_ram_pkg::resp_t       rresp,
    input  logic                      rready
);

    localparam int OFS_BITS = $clog2(`AXIL_DATA_WIDTH/8);
    localparam int IDX_BITS = $bits(axil_ram_pkg::word_idx_t);

    logic                pend_q;   // Store read in progress
    logic                rvalid_q;
    axil_ram_pkg::resp_t rresp_q;
    axil_ram_pkg::data_t rdata_q;
    logic                addr_ok;

    assign ar_ready = !pend_q && !rvalid_q;

    assign addr_ok = (ar_addr[OFS_BITS-1:0] == '0) &&
                     (ar_addr < axil_ram_pkg::addr_t'(`AXIL_RAM_BYTES));

    assign store_re   = ar_valid && ar_ready && addr_ok;
    assign store_ridx = ar_addr[OFS_BITS +: IDX_BITS];

    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;
    assign rresp  = rresp_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            pend_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            pend_q <= ar_valid && ar_ready;
            if (pend_q) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (ar_valid && ar_ready) begin
            rresp_q <= addr_ok ? axil_ram_pkg::RESP_OKAY : axil_ram_pkg::RESP_DECERR;
        end
        if (pend_q) begin
            // Zero data on a decode error
            rdata_q <= (rresp_q == axil_ram_pkg::RESP_OKAY) ? store_rdata : '0;
        end
    end

endmodule

// File: src/axil_ram_wr.sv
`include "axil_ram_defs.svh"

module axil_ram_wr (
    input  logic                      seq,
    input  logic                      reset,

    input  logic                      aw_valid,
    input  axil_ram_pkg::addr_t       aw_addr,
    output logic                      aw_ready,

    input  logic                      w_valid,
    input  axil_ram_pkg::w_beat_t     w_beat,
    output logic                      w_ready,

    output logic                      bvalid,
    output axil_ram_pkg::resp_t       bresp,
    input  logic                      bready,

    output logic                      store_we,
    output axil_ram_pkg::word_idx_t   store_widx,
    output axil_ram_pkg::data_t       store_wdata,
    output axil_ram_pkg::strb_t       store_wstrb
);

    localparam int OFS_BITS = $clog2(`AXIL_DATA_WIDTH/8);
    localparam int IDX_BITS = $bits(axil_ram_pkg::word_idx_t);

    logic                bvalid_q;
    axil_ram_pkg::resp_t bresp_q;
    logic                take;
    logic                addr_ok;

    // Both beats leave their buffers in the same cycle
    assign take     = aw_valid && w_valid && !bvalid_q;
    assign aw_ready = w_valid && !bvalid_q;
    assign w_ready  = aw_valid && !bvalid_q;

    // Word aligned and inside the array
    assign addr_ok = (aw_addr[OFS_BITS-1:0] == '0) &&
                     (aw_addr < axil_ram_pkg::addr_t'(`AXIL_RAM_BYTES));

    assign store_we    = take && addr_ok;
    assign store_widx  = aw_addr[OFS_BITS +: IDX_BITS];
    assign store_wdata = w_beat.data;
    assign store_wstrb = w_beat.strb;

    assign bvalid = bvalid_q;
    assign bresp  = bresp_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            bvalid_q <= 1'b0;
        end else if (take) begin
            bvalid_q <= 1'b1;
        end else if (bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // Response code for the beat just consumed
    always_ff @(posedge seq) begin
        if (take) begin
            bresp_q <= addr_ok ? axil_ram_pkg::RESP_OKAY : axil_ram_pkg::RESP_DECERR;
        end
    end

endmodule

// File: src/axil_chan_buf.sv
module axil_chan_buf #(
    parameter type payload_t = axil_ram_pkg::addr_t
) (
    input  logic     seq,
    input  logic     reset,
    input  logic     pause,

    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_ready
);

    logic     full_q;
    logic     ready_en_q; // Holds ready low until the cycle after reset
    payload_t payload_q;

    assign in_ready    = ready_en_q && !full_q && !pause;
    assign out_valid   = full_q;
    assign out_payload = payload_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            full_q     <= 1'b0;
            ready_en_q <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            if (in_valid && in_ready) begin
                full_q <= 1'b1;
            end else if (out_ready) begin
                full_q <= 1'b0; // Handler took the entry
            end
        end
    end

    always_ff @(posedge seq) begin
        if (in_valid && in_ready) payload_q <= in_payload;
    end

endmodule

// File: src/axil_ram_pkg.sv
`include "axil_ram_defs.svh"

package axil_ram_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;

    // AXI response encodings
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // W channel beat as it sits in the buffer
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_beat_t;

    typedef logic [$clog2(`AXIL_RAM_BYTES/(`AXIL_DATA_WIDTH/8))-1:0] word_idx_t;

endpackage

// File: src/axil_ram_defs.svh
`ifndef AXIL_RAM_DEFS_SVH
`define AXIL_RAM_DEFS_SVH

// Byte address width of the AXI4-Lite port
`define AXIL_ADDR_WIDTH 32

// Data word width, also sets the strobe count
`define AXIL_DATA_WIDTH 32

// Decoded memory size; addresses at or above this answer DECERR
`define AXIL_RAM_BYTES 4096

`endif
